// File: verilog/netfifo_defines.svh
// Size macros for the packet FIFO, included by packages and RTL that need widths
`ifndef NETFIFO_DEFINES_SVH
`define NETFIFO_DEFINES_SVH

//////////////////////////////////////////////////
// Stream payload
//////////////////////////////////////////////////

// Bits in one data byte of the stream
`define NF_DATA_WIDTH 8

//////////////////////////////////////////////////
// Storage
//////////////////////////////////////////////////

// Log2 of the FIFO depth
// 4 gives 16 beats of storage
// Pointers carry one extra bit above this
`define NF_LGFLEN 4

`endif

// File: verilog/stream_pkg.sv
// Stream-side types shared by the bus interface, memory word and read control
`default_nettype none

`include "netfifo_defines.svh"

package stream_pkg;

	// One data byte of the stream
	typedef logic [`NF_DATA_WIDTH-1:0] nf_data_t;

	// Stored word
	// Last flag sits above the data byte
	typedef struct packed {
		logic     last;
		nf_data_t data;
	} nf_beat_t;

	// Output side packet tracking
	// Midpacket once a non-last beat has gone out
	typedef enum logic {
		out_idle,
		out_midpacket
	} out_state_e;

endpackage

`default_nettype wire

// File: verilog/fifo_pkg.sv
// FIFO bookkeeping types shared by the pointer interface and the control blocks
`default_nettype none

`include "netfifo_defines.svh"

package fifo_pkg;

	// Pointer with one wrap bit above the address
	// Equal pointers mean empty, MSB-only difference means full
	typedef logic [`NF_LGFLEN:0] ptr_t;

	// Memory word address
	typedef logic [`NF_LGFLEN-1:0] addr_t;

	// Input side packet tracking
	// An abort only counts while midpacket
	typedef enum logic {
		in_idle,
		in_midpacket
	} in_state_e;

endpackage

`default_nettype wire

// File: verilog/axin_if.sv
// Abortable stream port bundle, one instance per stream direction inside the FIFO
`timescale 1ns/100ps
`default_nettype none

interface axin_if;
	import stream_pkg::*;

	// Handshake
	logic     valid;
	logic     ready;

	// Payload
	nf_data_t data;
	logic     last;

	// Ends the current packet early
	logic     abort;

	// Receiving end, owns ready
	modport sink (
		input  valid,
		output ready,
		input  data,
		input  last,
		input  abort
	);

	// Sending end, owns everything but ready
	modport source (
		output valid,
		input  ready,
		output data,
		output last,
		output abort
	);

endinterface

`default_nettype wire

// File: verilog/fifo_ptr_if.sv
// Pointer and packet status bundle linking write control, read control and memory
`timescale 1ns/100ps
`default_nettype none

interface fifo_ptr_if;
	import stream_pkg::*;
	import fifo_pkg::*;

	// Write side
	ptr_t     wr_ptr;
	logic     wr_en;
	nf_beat_t wr_beat;
	logic     pkt_stored;
	logic     abort_taken;

	// Read side
	ptr_t     rd_ptr;
	logic     rd_fire;
	nf_beat_t rd_beat;

	modport wr_side (
		output wr_ptr, wr_en, wr_beat, pkt_stored, abort_taken,
		input  rd_ptr, rd_fire
	);

	modport rd_side (
		output rd_ptr, rd_fire,
		input  wr_ptr, pkt_stored, abort_taken, rd_beat
	);

	// Memory sees both pointers, returns the head word
	modport mem_side (
		input  wr_ptr, wr_en, wr_beat, rd_ptr,
		output rd_beat
	);

endinterface

`default_nettype wire

// File: verilog/netfifo_wr_ctrl.sv
// Write side of the packet FIFO, instantiated once by the top level
`timescale 1ns/100ps
`default_nettype none

`include "netfifo_defines.svh"

module netfifo_wr_ctrl (
	input  logic       S_AXI_ACLK,
	input  logic       S_AXI_ARESETN,
	axin_if.sink       in_bus,
	fifo_ptr_if.wr_side ptr
);
	import fifo_pkg::*;

	ptr_t      fill;
	ptr_t      eop_ptr;
	ptr_t      rewind_ptr;
	in_state_e in_state;
	logic      full;
	logic      in_fire;
	logic      out_valid;

	//////////////////////////////////////////////////
	// Occupancy and back-pressure
	//////////////////////////////////////////////////

	// Wrap bit set in the difference means full
	assign fill      = ptr.wr_ptr - ptr.rd_ptr;
	assign full      = fill[`NF_LGFLEN];
	assign out_valid = (ptr.wr_ptr != ptr.rd_ptr);

	// Abort is always taken, even when full
	always_comb
	begin
		if (in_bus.abort)
			in_bus.ready = 1'b1;
		else
			in_bus.ready = !full;
	end

	// Accepted beat, never on an abort cycle
	assign in_fire     = in_bus.valid && in_bus.ready && !in_bus.abort;
	assign ptr.wr_en   = in_fire;
	assign ptr.wr_beat = '{last: in_bus.last, data: in_bus.data};

	//////////////////////////////////////////////////
	// Packet tracking
	//////////////////////////////////////////////////

	// Input side state
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			in_state <= in_idle;
		else if (in_bus.abort)
			in_state <= in_idle;
		else if (in_fire)
			in_state <= in_bus.last ? in_idle : in_midpacket;
	end

	// Abort outside a packet is ignored
	assign ptr.abort_taken = in_bus.abort && (in_state == in_midpacket);

	// Address of the newest end-of-packet beat
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (in_fire && in_bus.last)
			eop_ptr <= ptr.wr_ptr;
	end

	// New last beat wins over the head packet leaving
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			ptr.pkt_stored <= 1'b0;
		else if (in_fire && in_bus.last)
			ptr.pkt_stored <= 1'b1;
		else if (ptr.rd_fire && (ptr.rd_ptr == eop_ptr))
			ptr.pkt_stored <= 1'b0;
	end

	//////////////////////////////////////////////////
	// Write pointer
	//////////////////////////////////////////////////

	// Rewind target on abort
	// Just past the last whole packet, else keep only the head beat
	always_comb
	begin
		if (ptr.pkt_stored)
			rewind_ptr = eop_ptr + 1'b1;
		else
			rewind_ptr = ptr.rd_ptr + 1'b1;
	end

	// Nothing stored and output idle means nothing to drop
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			ptr.wr_ptr <= '0;
		else if (ptr.abort_taken)
		begin
			if (ptr.pkt_stored || out_valid)
				ptr.wr_ptr <= rewind_ptr;
		end
		else if (in_fire)
			ptr.wr_ptr <= ptr.wr_ptr + 1'b1;
	end

endmodule

`default_nettype wire

// File: verilog/netfifo_mem.sv
// Beat storage of the packet FIFO, written by the input side and read combinationally
`timescale 1ns/100ps
`default_nettype none

`include "netfifo_defines.svh"

module netfifo_mem (
	input  logic         S_AXI_ACLK,
	fifo_ptr_if.mem_side ptr
);
	import stream_pkg::*;
	import fifo_pkg::*;

	localparam int FLEN = 1 << `NF_LGFLEN;

	nf_beat_t mem [0:FLEN-1];
	addr_t    wr_addr;
	addr_t    rd_addr;

	// Wrap bit dropped for the array index
	assign wr_addr = ptr.wr_ptr[`NF_LGFLEN-1:0];
	assign rd_addr = ptr.rd_ptr[`NF_LGFLEN-1:0];

	// Synchronous write
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (ptr.wr_en)
			mem[wr_addr] <= ptr.wr_beat;
	end

	// Head word, no read latency
	assign ptr.rd_beat = mem[rd_addr];

endmodule

`default_nettype wire

// File: verilog/netfifo_rd_ctrl.sv
// Read side of the packet FIFO, drives the output stream including its abort
`timescale 1ns/100ps
`default_nettype none

module netfifo_rd_ctrl (
	input  logic        S_AXI_ACLK,
	input  logic        S_AXI_ARESETN,
	axin_if.source      out_bus,
	fifo_ptr_if.rd_side ptr,
	input  logic        in_abort
);
	import stream_pkg::*;

	out_state_e out_state;
	logic       abort_hit;
	logic       abort_done;

	//////////////////////////////////////////////////
	// Output beat
	//////////////////////////////////////////////////

	// Valid whenever anything is stored
	assign out_bus.valid = (ptr.wr_ptr != ptr.rd_ptr);
	assign out_bus.data  = ptr.rd_beat.data;
	assign out_bus.last  = ptr.rd_beat.last;

	assign ptr.rd_fire = out_bus.valid && out_bus.ready;

	// Read pointer
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			ptr.rd_ptr <= '0;
		else if (ptr.rd_fire)
			ptr.rd_ptr <= ptr.rd_ptr + 1'b1;
	end

	//////////////////////////////////////////////////
	// Output abort
	//////////////////////////////////////////////////

	// Input abort hit a packet with no whole packet behind it
	assign abort_hit = in_abort && ptr.abort_taken && !ptr.pkt_stored;

	// Abort seen by the consumer, or nothing left to abort
	assign abort_done = out_bus.abort && (!out_bus.valid || out_bus.ready);

	// Output side state
	// An accepted abort closes the packet
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			out_state <= out_idle;
		else if (abort_done)
			out_state <= out_idle;
		else if (ptr.rd_fire)
			out_state <= out_bus.last ? out_idle : out_midpacket;
	end

	// Raised only when the consumer already holds part of the packet
	// Held until accepted
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			out_bus.abort <= 1'b0;
		else if (!out_bus.abort)
			out_bus.abort <= abort_hit
				&& (out_bus.valid || (out_state == out_midpacket));
		else if (abort_done)
			out_bus.abort <= 1'b0;
	end

endmodule

`default_nettype wire

// File: verilog/netfifo_top.sv
// Abortable packet FIFO top level, instantiate this with plain stream ports
`timescale 1ns/100ps
`default_nettype none

module netfifo_top (
	input  logic                 S_AXI_ACLK,
	input  logic                 S_AXI_ARESETN,
	// Input stream
	input  logic                 s_valid,
	output logic                 s_ready,
	input  stream_pkg::nf_data_t s_data,
	input  logic                 s_last,
	input  logic                 s_abort,
	// Output stream
	output logic                 m_valid,
	input  logic                 m_ready,
	output stream_pkg::nf_data_t m_data,
	output logic                 m_last,
	output logic                 m_abort
);

	//////////////////////////////////////////////////
	// Internal buses
	//////////////////////////////////////////////////

	axin_if     in_bus ();
	axin_if     out_bus ();
	fifo_ptr_if ptr_bus ();

	// Input port onto the sink bus
	assign in_bus.valid = s_valid;
	assign in_bus.data  = s_data;
	assign in_bus.last  = s_last;
	assign in_bus.abort = s_abort;
	assign s_ready      = in_bus.ready;

	// Source bus out to the output port
	assign out_bus.ready = m_ready;
	assign m_valid       = out_bus.valid;
	assign m_data        = out_bus.data;
	assign m_last        = out_bus.last;
	assign m_abort       = out_bus.abort;

	//////////////////////////////////////////////////
	// Blocks
	//////////////////////////////////////////////////

	netfifo_wr_ctrl u_wr_ctrl (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.in_bus        (in_bus),
		.ptr           (ptr_bus)
	);

	netfifo_mem u_mem (
		.S_AXI_ACLK (S_AXI_ACLK),
		.ptr        (ptr_bus)
	);

	// Raw abort also goes to the read side for m_abort
	netfifo_rd_ctrl u_rd_ctrl (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.out_bus       (out_bus),
		.ptr           (ptr_bus),
		.in_abort      (s_abort)
	);

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
// Clock and reset source for the FIFO testbench, instantiated once by the testbench top
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD       = 100,
	parameter int RESET_CYCLES = 5
) (
	output logic clk,
	output logic rst_n
);

	// Free-running clock, starts low
	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD / 2) clk = ~clk;
	end

	// Reset over the first rising edges
	// Released on a falling edge, clear of the sampling edge
	initial
	begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES)
			@(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: tb/tb_netfifo.sv
// Directed testbench for the abortable packet FIFO, top module of the simulation
`timescale 1ns/100ps
`default_nettype none

module tb_netfifo;
	import stream_pkg::*;

	localparam int PERIOD      = 100;
	localparam int FIFO_DEPTH  = 16;
	localparam int PT_LEN      = 5;
	// Pushed plus popped beats over all tests
	localparam int TOTAL_BEATS = 64;
	localparam int TIMEOUT_NS  = (TOTAL_BEATS * 4 + 100) * PERIOD;

	logic     clk;
	logic     rst_n;
	logic     s_valid;
	logic     s_ready;
	nf_data_t s_data;
	logic     s_last;
	logic     s_abort;
	logic     m_valid;
	logic     m_ready;
	nf_data_t m_data;
	logic     m_last;
	logic     m_abort;

	integer   seed;
	// Expected output beats in arrival order
	nf_beat_t sent [$];

	tb_clock_gen #(.PERIOD(PERIOD), .RESET_CYCLES(5)) clk_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	netfifo_top uut (
		.S_AXI_ACLK    (clk),
		.S_AXI_ARESETN (rst_n),
		.s_valid       (s_valid),
		.s_ready       (s_ready),
		.s_data        (s_data),
		.s_last        (s_last),
		.s_abort       (s_abort),
		.m_valid       (m_valid),
		.m_ready       (m_ready),
		.m_data        (m_data),
		.m_last        (m_last),
		.m_abort       (m_abort)
	);

	//////////////////////////////////////////////////
	// Checking
	//////////////////////////////////////////////////

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_data(input string name, input nf_data_t exp, input nf_data_t got);
		if (got !== exp)
			stop_run($sformatf("mismatch at %0t ns: %s expected %h got %h",
				$time, name, exp, got));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic got);
		if (got !== exp)
			stop_run($sformatf("mismatch at %0t ns: %s expected %b got %b",
				$time, name, exp, got));
	endtask

	//////////////////////////////////////////////////
	// Stream drivers
	//////////////////////////////////////////////////

	// All drivers start and end on a falling edge
	// Outputs are sampled at the rising edge before registers move
	task automatic push_beat(input nf_beat_t beat);
		s_valid = 1'b1;
		s_data  = beat.data;
		s_last  = beat.last;
		@(posedge clk);
		while (!s_ready)
			@(posedge clk);
		check_flag("m_abort", 1'b0, m_abort);
		@(negedge clk);
		s_valid = 1'b0;
		s_last  = 1'b0;
	endtask

	// Random byte that is also queued as expected output
	task automatic push_random(input logic last);
		nf_beat_t beat;
		beat.data = nf_data_t'($random(seed));
		beat.last = last;
		sent.push_back(beat);
		push_beat(beat);
	endtask

	task automatic send_beats(input int count, input logic end_last);
		for (int i = 0; i < count; i++)
			push_random(end_last && (i == count - 1));
	endtask

	task automatic pop_beat(input nf_beat_t exp);
		m_ready = 1'b1;
		@(posedge clk);
		while (!m_valid)
			@(posedge clk);
		check_data("m_data", exp.data, m_data);
		check_flag("m_last", exp.last, m_last);
		check_flag("m_abort", 1'b0, m_abort);
		@(negedge clk);
		m_ready = 1'b0;
	endtask

	task automatic drain_beats(input int count);
		nf_beat_t beat;
		repeat (count)
		begin
			if (sent.size() == 0)
				stop_run("Output drain asked for more beats than were sent");
			beat = sent.pop_front();
			pop_beat(beat);
		end
	endtask

	// One cycle of input abort that is always taken
	task automatic abort_input();
		s_abort = 1'b1;
		@(posedge clk);
		check_flag("s_ready", 1'b1, s_ready);
		@(negedge clk);
		s_abort = 1'b0;
	endtask

	task automatic expect_empty();
		@(posedge clk);
		check_flag("m_valid", 1'b0, m_valid);
		check_flag("m_abort", 1'b0, m_abort);
		@(negedge clk);
	endtask

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////

	task automatic test_reset();
		@(posedge clk);
		check_flag("s_ready", 1'b1, s_ready);
		check_flag("m_valid", 1'b0, m_valid);
		check_flag("m_abort", 1'b0, m_abort);
		@(negedge clk);
	endtask

	// First beat shows up one edge after it is taken
	task automatic test_pass_through();
		expect_empty();
		push_random(1'b0);
		@(posedge clk);
		check_flag("m_valid", 1'b1, m_valid);
		check_data("m_data", sent[0].data, m_data);
		@(negedge clk);
		send_beats(PT_LEN - 1, 1'b1);
		drain_beats(PT_LEN);
		expect_empty();
	endtask

	task automatic test_back_pressure();
		send_beats(FIFO_DEPTH, 1'b1);
		// Extra beat offered while full must stay out
		s_valid = 1'b1;
		s_data  = nf_data_t'($random(seed));
		repeat (2)
		begin
			@(posedge clk);
			check_flag("s_ready", 1'b0, s_ready);
		end
		@(negedge clk);
		s_valid = 1'b0;
		drain_beats(FIFO_DEPTH);
		expect_empty();
	endtask

	// Stored packet survives while the partial one vanishes
	task automatic test_abort_stored();
		send_beats(3, 1'b1);
		send_beats(4, 1'b0);
		abort_input();
		repeat (4)
			sent.delete(sent.size() - 1);
		drain_beats(3);
		expect_empty();
	endtask

	// Only the head beat stays and the output carries the abort
	task automatic test_abort_unstored();
		nf_beat_t head;
		send_beats(3, 1'b0);
		abort_input();
		head = sent[0];
		sent.delete();
		// Abort held while the consumer stalls
		repeat (3)
		begin
			@(posedge clk);
			check_flag("m_abort", 1'b1, m_abort);
			check_flag("m_valid", 1'b1, m_valid);
		end
		@(negedge clk);
		m_ready = 1'b1;
		@(posedge clk);
		check_flag("m_abort", 1'b1, m_abort);
		check_data("m_data", head.data, m_data);
		@(negedge clk);
		m_ready = 1'b0;
		expect_empty();
		// Next packet unaffected
		send_beats(4, 1'b1);
		drain_beats(4);
		expect_empty();
	endtask

	//////////////////////////////////////////////////
	// Sequence and watchdog
	//////////////////////////////////////////////////

	initial
	begin
		seed    = 32'h72c0;
		s_valid = 1'b0;
		s_data  = '0;
		s_last  = 1'b0;
		s_abort = 1'b0;
		m_ready = 1'b0;
		wait (rst_n === 1'b1);
		test_reset();
		test_pass_through();
		test_back_pressure();
		test_abort_stored();
		test_abort_unstored();
		$display("No errors");
		$finish;
	end

	// Bound on the whole run scaled by beat count
	initial
	begin
		#(TIMEOUT_NS);
		stop_run("Run timed out before all tests finished");
	end

endmodule

`default_nettype wire

// File: files.f
+incdir+verilog
verilog/stream_pkg.sv
verilog/fifo_pkg.sv
verilog/axin_if.sv
verilog/fifo_ptr_if.sv
verilog/netfifo_wr_ctrl.sv
verilog/netfifo_mem.sv
verilog/netfifo_rd_ctrl.sv
verilog/netfifo_top.sv
tb/tb_clock_gen.sv
tb/tb_netfifo.sv
